// ==== all.f ====
+incdir+design
design/aes_cop_pkg.sv
design/aes_sbox.sv
design/aes_cop_unit.sv
design/aes_cop_issue.sv
design/aes_cop_regfile.sv
design/aes_cop_top.sv
testbench/tb_aes_cop.sv

// ==== design/aes_cop_config.svh ====
// AES co-processor configuration
`ifndef AES_COP_CONFIG_SVH
`define AES_COP_CONFIG_SVH

// Register file depth
`define AES_COP_NUM_REGS       16

// Field widths
`define AES_COP_XLEN           32
`define AES_COP_REG_IDX_W      4
`define AES_COP_CLASS_W        4
`define AES_COP_SCLASS_W       5

// Instruction class for the AES group
`define AES_COP_CLASS_AES      4'h5

// AES subclass codes
`define AES_COP_SC_SUB_ENC     5'h01
`define AES_COP_SC_SUB_ENCROT  5'h02
`define AES_COP_SC_SUB_DEC     5'h03
`define AES_COP_SC_SUB_DECROT  5'h04
`define AES_COP_SC_MIX_ENC     5'h05
`define AES_COP_SC_MIX_DEC     5'h06

`endif

// ==== design/aes_cop_issue.sv ====
// AES instruction issue stage
`timescale 1ns/1ns
`default_nettype none

`include "aes_cop_config.svh"

module aes_cop_issue (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic                   instr_valid,
    input  aes_cop_pkg::aes_instr_t instr,
    output aes_cop_pkg::reg_idx_t  rs1_idx,
    output aes_cop_pkg::reg_idx_t  rs2_idx,
    output logic                   unit_valid,
    output aes_cop_pkg::aes_op_t   op,
    input  logic                   unit_done,
    input  aes_cop_pkg::word_t     result,
    input  aes_cop_pkg::ben_t      ben,
    output aes_cop_pkg::wb_t       wb,
    output logic                   wb_valid,
    output logic                   busy,
    output logic                   done,
    output logic                   illegal,
    output logic                   dropped
);

    aes_cop_pkg::issue_state_t state;
    aes_cop_pkg::aes_op_t      dec_op;
    aes_cop_pkg::aes_op_t      op_q;
    aes_cop_pkg::reg_idx_t     rd_q;
    aes_cop_pkg::reg_idx_t     rs1_q;
    aes_cop_pkg::reg_idx_t     rs2_q;
    logic                      legal;
    logic                      idle;
    logic                      accept;

    always_comb begin
        legal  = (instr.cls == `AES_COP_CLASS_AES);
        dec_op = '0;
        case (instr.subclass)
            `AES_COP_SC_SUB_ENC:    dec_op = '{is_mix: 1'b0, encrypt: 1'b1, rotate: 1'b0};
            `AES_COP_SC_SUB_ENCROT: dec_op = '{is_mix: 1'b0, encrypt: 1'b1, rotate: 1'b1};
            `AES_COP_SC_SUB_DEC:    dec_op = '{is_mix: 1'b0, encrypt: 1'b0, rotate: 1'b0};
            `AES_COP_SC_SUB_DECROT: dec_op = '{is_mix: 1'b0, encrypt: 1'b0, rotate: 1'b1};
            `AES_COP_SC_MIX_ENC:    dec_op = '{is_mix: 1'b1, encrypt: 1'b1, rotate: 1'b0};
            `AES_COP_SC_MIX_DEC:    dec_op = '{is_mix: 1'b1, encrypt: 1'b0, rotate: 1'b0};
            default:                legal  = 1'b0;
        endcase
    end

    assign idle   = (state == aes_cop_pkg::ISSUE_IDLE);
    assign accept = instr_valid && idle && legal;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state   <= aes_cop_pkg::ISSUE_IDLE;
            done    <= 1'b0;
            illegal <= 1'b0;
            dropped <= 1'b0;
        end else begin
            done    <= unit_done;
            illegal <= instr_valid && idle && !legal;
            dropped <= instr_valid && !idle;    // No queueing behind a busy unit
            case (state)
                aes_cop_pkg::ISSUE_IDLE: if (accept) state <= aes_cop_pkg::ISSUE_BUSY;
                aes_cop_pkg::ISSUE_BUSY: if (unit_done) state <= aes_cop_pkg::ISSUE_IDLE;
            endcase
        end
    end

    // Instruction fields for the duration of the run
    always_ff @(posedge g_clk) begin
        if (accept) begin
            op_q  <= dec_op;
            rd_q  <= instr.rd;
            rs1_q <= instr.rs1;
            rs2_q <= instr.rs2;
        end
    end

    assign busy       = !idle;
    assign unit_valid = !idle;    // Falls the cycle after unit_done
    assign op         = op_q;
    assign rs1_idx    = rs1_q;
    assign rs2_idx    = rs2_q;
    assign wb_valid   = unit_done;
    assign wb         = '{ben: ben, addr: rd_q, data: result};

    // Writeback lands in the fourth busy cycle of an accepted run
    a_wb_timing: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        wb_valid |-> $past(accept, 4)
    ) else $error("writeback not four cycles after an accepted instruction");

endmodule

`default_nettype wire

// ==== design/aes_cop_pkg.sv ====
// AES co-processor types
`default_nettype none

`include "aes_cop_config.svh"

package aes_cop_pkg;

    typedef logic [`AES_COP_XLEN-1:0]       word_t;
    typedef logic [`AES_COP_XLEN/8-1:0]     ben_t;     // One bit per byte lane
    typedef logic [`AES_COP_REG_IDX_W-1:0]  reg_idx_t;
    typedef logic [`AES_COP_CLASS_W-1:0]    class_t;
    typedef logic [`AES_COP_SCLASS_W-1:0]   sclass_t;
    typedef logic [1:0]                     step_t;    // Four execution steps

    // Decoded instruction from the core
    typedef struct packed {
        class_t   cls;
        sclass_t  subclass;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } aes_instr_t;

    // Operation handed to the execution unit
    typedef struct packed {
        logic is_mix;    // MixColumn, else SubBytes
        logic encrypt;
        logic rotate;    // One byte rotate of the SubBytes result
    } aes_op_t;

    // Register writeback
    typedef struct packed {
        ben_t     ben;
        reg_idx_t addr;
        word_t    data;
    } wb_t;

    typedef enum logic {
        ISSUE_IDLE,
        ISSUE_BUSY
    } issue_state_t;

endpackage

`default_nettype wire

// ==== design/aes_cop_regfile.sv ====
// AES co-processor register file
`timescale 1ns/1ns
`default_nettype none

`include "aes_cop_config.svh"

module aes_cop_regfile (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  aes_cop_pkg::reg_idx_t rs1_idx,
    input  aes_cop_pkg::reg_idx_t rs2_idx,
    output aes_cop_pkg::word_t    rs1_data,
    output aes_cop_pkg::word_t    rs2_data,
    input  logic                  wb_valid,
    input  aes_cop_pkg::wb_t      wb,
    input  logic                  load_valid,
    input  aes_cop_pkg::reg_idx_t load_addr,
    input  aes_cop_pkg::word_t    load_data,
    input  aes_cop_pkg::reg_idx_t read_addr,
    output aes_cop_pkg::word_t    read_data
);

    aes_cop_pkg::word_t regs [`AES_COP_NUM_REGS];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < `AES_COP_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin    // Writeback wins over host load
            for (int j = 0; j < 4; j++) begin
                if (wb.ben[j])
                    regs[wb.addr][8*j +: 8] <= wb.data[8*j +: 8];
            end
        end else if (load_valid) begin
            regs[load_addr] <= load_data;
        end
    end

    // Asynchronous reads
    assign rs1_data  = regs[rs1_idx];
    assign rs2_data  = regs[rs2_idx];
    assign read_data = regs[read_addr];

endmodule

`default_nettype wire

// ==== design/aes_cop_top.sv ====
// AES co-processor top level
`timescale 1ns/1ns
`default_nettype none

module aes_cop_top (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    instr_valid,
    input  aes_cop_pkg::aes_instr_t instr,
    input  logic                    load_valid,
    input  aes_cop_pkg::reg_idx_t   load_addr,
    input  aes_cop_pkg::word_t      load_data,
    input  aes_cop_pkg::reg_idx_t   read_addr,
    output aes_cop_pkg::word_t      read_data,
    output logic                    busy,
    output logic                    done,
    output logic                    illegal,
    output logic                    dropped
);

    aes_cop_pkg::reg_idx_t rs1_idx;
    aes_cop_pkg::reg_idx_t rs2_idx;
    aes_cop_pkg::word_t    rs1_data;
    aes_cop_pkg::word_t    rs2_data;
    aes_cop_pkg::aes_op_t  op;
    aes_cop_pkg::word_t    result;
    aes_cop_pkg::ben_t     ben;
    aes_cop_pkg::wb_t      wb;
    logic                  unit_valid;
    logic                  unit_done;
    logic                  wb_valid;

    aes_cop_issue u_issue (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .unit_valid  (unit_valid),
        .op          (op),
        .unit_done   (unit_done),
        .result      (result),
        .ben         (ben),
        .wb          (wb),
        .wb_valid    (wb_valid),
        .busy        (busy),
        .done        (done),
        .illegal     (illegal),
        .dropped     (dropped)
    );

    aes_cop_regfile u_regfile (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .wb_valid   (wb_valid),
        .wb         (wb),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .read_addr  (read_addr),
        .read_data  (read_data)
    );

    aes_cop_unit u_unit (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .unit_valid (unit_valid),
        .op         (op),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .unit_done  (unit_done),
        .ben        (ben),
        .result     (result)
    );

endmodule

`default_nettype wire

// ==== design/aes_cop_unit.sv ====
// AES four-step execution unit
`timescale 1ns/1ns
`default_nettype none

module aes_cop_unit (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  logic                unit_valid,
    input  aes_cop_pkg::aes_op_t op,
    input  aes_cop_pkg::word_t  rs1_data,
    input  aes_cop_pkg::word_t  rs2_data,
    output logic                unit_done,
    output aes_cop_pkg::ben_t   ben,
    output aes_cop_pkg::word_t  result
);

    aes_cop_pkg::step_t step;
    aes_cop_pkg::word_t col;       // {t3, t2, t1, t0}
    aes_cop_pkg::word_t rot;       // Column rotated so the current row leads
    aes_cop_pkg::word_t tmp_q;     // Partial result
    aes_cop_pkg::ben_t  pos_sel;   // One-hot target byte
    logic [1:0]         pos;
    logic [7:0]         t_cur;
    logic [7:0]         sbox_out;
    logic [7:0]         mix_out;
    logic [7:0]         new_byte;

    // Small constant multiply in GF(2^8), coefficient up to 0xf
    function automatic logic [7:0] gf_mul4(input logic [7:0] a, input logic [3:0] c);
        logic [7:0] acc;
        logic [7:0] sh;
        acc = 8'h00;
        sh  = a;
        for (int i = 0; i < 4; i++) begin
            if (c[i])
                acc = acc ^ sh;
            sh = {sh[6:0], 1'b0} ^ (sh[7] ? 8'h1b : 8'h00);
        end
        return acc;
    endfunction

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            step <= 2'd0;
        end else if (unit_valid) begin
            step <= step + 2'd1;    // Wraps after step 3
        end
    end

    // Source bytes alternate between the two operands
    assign col   = {rs2_data[31:24], rs1_data[23:16], rs2_data[15:8], rs1_data[7:0]};
    assign t_cur = col[8*step +: 8];

    aes_sbox u_sbox (
        .in  (t_cur),
        .inv (!op.encrypt),
        .out (sbox_out)
    );

    always_comb begin
        rot = (col >> {step, 3'b000}) | (col << (6'd32 - {1'b0, step, 3'b000}));
        if (op.encrypt) begin
            mix_out = gf_mul4(rot[7:0], 4'h2) ^ gf_mul4(rot[15:8], 4'h3)
                    ^ rot[23:16] ^ rot[31:24];
        end else begin
            mix_out = gf_mul4(rot[7:0], 4'he) ^ gf_mul4(rot[15:8], 4'hb)
                    ^ gf_mul4(rot[23:16], 4'hd) ^ gf_mul4(rot[31:24], 4'h9);
        end
    end

    // MixColumn fills from the top byte down
    assign pos      = op.is_mix ? ~step : step + {1'b0, op.rotate};
    assign pos_sel  = 4'b0001 << pos;
    assign new_byte = op.is_mix ? mix_out : sbox_out;

    always_ff @(posedge g_clk) begin
        if (unit_valid) begin
            for (int j = 0; j < 4; j++) begin
                if (pos_sel[j])
                    tmp_q[8*j +: 8] <= new_byte;
            end
        end
    end

    // Current byte bypasses the register so step 3 completes in place
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            result[8*j +: 8] = pos_sel[j] ? new_byte : tmp_q[8*j +: 8];
        end
    end

    assign unit_done = unit_valid && (step == 2'd3);
    assign ben       = {4{unit_done}};

    // Issue side must hold the request until the final step
    a_op_held: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        unit_valid && !unit_done |=> unit_valid && $stable(op)
    ) else $error("op changed or valid dropped before done");

    // Done only after a full four-step run
    a_done_after_run: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        unit_done |-> unit_valid && $past(unit_valid, 3)
    ) else $error("unit_done without four valid cycles");

endmodule

`default_nettype wire

// ==== design/aes_sbox.sv ====
// AES forward and inverse S-box
`timescale 1ns/1ns
`default_nettype none

module aes_sbox (
    input  logic [7:0] in,
    input  logic       inv,    // High selects the inverse box
    output logic [7:0] out
);

    logic [7:0] field_in;
    logic [7:0] field_inv;

    // Multiply by x modulo 0x11b
    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] sh;
        acc = 8'h00;
        sh  = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i])
                acc = acc ^ sh;
            sh = xtime(sh);
        end
        return acc;
    endfunction

    // Inverse as a^254, product of a^(2^i) for i = 1..7
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] pw;
        logic [7:0] acc;
        pw  = a;
        acc = 8'h01;
        for (int i = 1; i < 8; i++) begin
            pw  = gf_mul(pw, pw);
            acc = gf_mul(acc, pw);
        end
        return acc;    // Zero stays zero
    endfunction

    function automatic logic [7:0] rotl(input logic [7:0] a, input int n);
        return (a << n) | (a >> (8 - n));
    endfunction

    function automatic logic [7:0] affine(input logic [7:0] b);
        return b ^ rotl(b, 1) ^ rotl(b, 2) ^ rotl(b, 3) ^ rotl(b, 4) ^ 8'h63;
    endfunction

    function automatic logic [7:0] inv_affine(input logic [7:0] s);
        return rotl(s, 1) ^ rotl(s, 3) ^ rotl(s, 6) ^ 8'h05;
    endfunction

    // Inverse box undoes the affine map before the field inverse
    assign field_in  = inv ? inv_affine(in) : in;
    assign field_inv = gf_inv(field_in);
    assign out       = inv ? field_inv : affine(field_inv);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AES co-processor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f all.f \
    --top-module tb_aes_cop \
    -Mdir obj_dir \
    -o sim_aes_cop

./obj_dir/sim_aes_cop | tee sim.log

if grep -q "^Verification passed$" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

// ==== testbench/tb_aes_cop.sv ====
// AES co-processor testbench
`timescale 1ns/1ns
`default_nettype none

`include "aes_cop_config.svh"

module tb_aes_cop;

    localparam int MAX_CYCLES = 40 * 8 + 100;

    logic                    g_clk = 1'b0;
    logic                    g_resetn;
    logic                    instr_valid;
    aes_cop_pkg::aes_instr_t instr;
    logic                    load_valid;
    aes_cop_pkg::reg_idx_t   load_addr;
    aes_cop_pkg::word_t      load_data;
    aes_cop_pkg::reg_idx_t   read_addr;
    aes_cop_pkg::word_t      read_data;
    logic                    busy;
    logic                    done;
    logic                    illegal;
    logic                    dropped;

    aes_cop_pkg::word_t    model_regs [16];    // Expected register contents
    aes_cop_pkg::sclass_t  sub_codes [4];
    logic [7:0]            sbox_fwd [256];
    logic [7:0]            sbox_inv [256];
    aes_cop_pkg::word_t    exp_word;           // Expected read_data at done or illegal
    logic                  zero_check;
    logic                  strobe_ok;
    logic                  strobe_bad;
    logic                  exp_busy;
    int                    run_left = 0;       // Unit steps left in the accepted run
    int                    assert_errors = 0;
    int                    wait_errors = 0;
    int                    cycles = 0;
    int                    n_instr = 0;
    int                    seed;

    aes_cop_top u_dut (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .load_valid  (load_valid),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .read_addr   (read_addr),
        .read_data   (read_data),
        .busy        (busy),
        .done        (done),
        .illegal     (illegal),
        .dropped     (dropped)
    );

    always #20 g_clk = ~g_clk;

    function automatic logic is_legal(input aes_cop_pkg::aes_instr_t i);
        logic sc_ok;
        sc_ok = (i.subclass == `AES_COP_SC_SUB_ENC) || (i.subclass == `AES_COP_SC_SUB_ENCROT)
             || (i.subclass == `AES_COP_SC_SUB_DEC) || (i.subclass == `AES_COP_SC_SUB_DECROT)
             || (i.subclass == `AES_COP_SC_MIX_ENC) || (i.subclass == `AES_COP_SC_MIX_DEC);
        return (i.cls == `AES_COP_CLASS_AES) && sc_ok;
    endfunction

    assign exp_busy   = (run_left != 0);
    assign strobe_ok  = instr_valid && !exp_busy && is_legal(instr);
    assign strobe_bad = instr_valid && !exp_busy && !is_legal(instr);

    // Busy spans the four unit steps after an accepted strobe
    always @(posedge g_clk) begin
        if (strobe_ok)
            run_left <= 4;
        else if (run_left != 0)
            run_left <= run_left - 1;
    end

    function automatic logic [7:0] xtime(input logic [7:0] a);
        return a[7] ? ({a[6:0], 1'b0} ^ 8'h1b) : {a[6:0], 1'b0};
    endfunction

    // Horner form, MSB of b first
    function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        acc = 8'h00;
        for (int i = 7; i >= 0; i--) begin
            acc = xtime(acc) ^ (b[i] ? a : 8'h00);
        end
        return acc;
    endfunction

    function automatic logic [7:0] field_inverse(input logic [7:0] a);
        logic [7:0] r;
        r = 8'h00;    // Zero has no inverse
        for (int b = 1; b < 256; b++) begin
            if (gmul(a, 8'(b)) == 8'h01)
                r = 8'(b);
        end
        return r;
    endfunction

    function automatic logic [7:0] affine(input logic [7:0] b);
        logic [7:0] s;
        for (int i = 0; i < 8; i++) begin
            s[i] = b[i] ^ b[(i + 4) % 8] ^ b[(i + 5) % 8] ^ b[(i + 6) % 8] ^ b[(i + 7) % 8];
        end
        return s ^ 8'h63;
    endfunction

    function automatic logic [7:0] mix_row(input aes_cop_pkg::word_t col, input int k,
                                           input logic enc);
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        a0 = col[8 * (k % 4) +: 8];
        a1 = col[8 * ((k + 1) % 4) +: 8];
        a2 = col[8 * ((k + 2) % 4) +: 8];
        a3 = col[8 * ((k + 3) % 4) +: 8];
        if (enc)
            return gmul(a0, 8'h02) ^ gmul(a1, 8'h03) ^ a2 ^ a3;
        return gmul(a0, 8'h0e) ^ gmul(a1, 8'h0b) ^ gmul(a2, 8'h0d) ^ gmul(a3, 8'h09);
    endfunction

    function automatic aes_cop_pkg::word_t expected_result(input aes_cop_pkg::sclass_t sc,
                                                           input aes_cop_pkg::word_t a,
                                                           input aes_cop_pkg::word_t b);
        aes_cop_pkg::word_t col;
        aes_cop_pkg::word_t res;
        logic [7:0]         t;
        int                 pos;
        logic               mix;
        logic               enc;
        logic               rot;
        col = {b[31:24], a[23:16], b[15:8], a[7:0]};    // t3 t2 t1 t0
        mix = (sc == `AES_COP_SC_MIX_ENC) || (sc == `AES_COP_SC_MIX_DEC);
        enc = (sc == `AES_COP_SC_SUB_ENC) || (sc == `AES_COP_SC_SUB_ENCROT)
           || (sc == `AES_COP_SC_MIX_ENC);
        rot = (sc == `AES_COP_SC_SUB_ENCROT) || (sc == `AES_COP_SC_SUB_DECROT);
        res = '0;
        for (int k = 0; k < 4; k++) begin
            t = col[8 * k +: 8];
            if (mix) begin
                res[8 * (3 - k) +: 8] = mix_row(col, k, enc);    // Row 0 lands in byte 3
            end else begin
                pos = rot ? (k + 1) % 4 : k;
                res[8 * pos +: 8] = enc ? sbox_fwd[t] : sbox_inv[t];
            end
        end
        return res;
    endfunction

    a_reset_flags: assert property (@(posedge g_clk)
        zero_check |-> !busy && !done && !illegal && !dropped)
        else begin
            assert_errors++;
            $display("MISMATCH flags: got %h expected 0", {busy, done, illegal, dropped});
        end

    a_reset_regs: assert property (@(posedge g_clk) zero_check |-> read_data == 32'h0)
        else begin
            assert_errors++;
            $display("MISMATCH read_data[%0d]: got %h expected 00000000", read_addr, read_data);
        end

    a_busy: assert property (@(posedge g_clk) disable iff (!g_resetn)
        busy == exp_busy)
        else begin
            assert_errors++;
            $display("MISMATCH busy: got %h expected %h", busy, exp_busy);
        end

    // Done exactly five edges after an accepted strobe
    a_done_timing: assert property (@(posedge g_clk) disable iff (!g_resetn)
        done == $past(strobe_ok, 5))
        else begin
            assert_errors++;
            $display("MISMATCH done: got %h expected %h", done, !done);
        end

    a_result: assert property (@(posedge g_clk) disable iff (!g_resetn)
        done |-> read_data == exp_word)
        else begin
            assert_errors++;
            $display("MISMATCH read_data: got %h expected %h", read_data, exp_word);
        end

    a_illegal: assert property (@(posedge g_clk) disable iff (!g_resetn)
        illegal == $past(strobe_bad))
        else begin
            assert_errors++;
            $display("MISMATCH illegal: got %h expected %h", illegal, !illegal);
        end

    a_illegal_idle: assert property (@(posedge g_clk) disable iff (!g_resetn)
        illegal |-> !busy)
        else begin
            assert_errors++;
            $display("Illegal instruction started the unit");
        end

    a_illegal_noreg: assert property (@(posedge g_clk) disable iff (!g_resetn)
        illegal |-> read_data == exp_word)
        else begin
            assert_errors++;
            $display("MISMATCH read_data: got %h expected %h", read_data, exp_word);
        end

    a_dropped: assert property (@(posedge g_clk) disable iff (!g_resetn)
        dropped == $past(instr_valid && exp_busy))
        else begin
            assert_errors++;
            $display("MISMATCH dropped: got %h expected %h", dropped, !dropped);
        end

    always @(posedge g_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, instruction sequence did not finish", cycles);
            $display("Errors: %0d assertion, %0d wait, 1 timeout; instructions: %0d",
                     assert_errors, wait_errors, n_instr);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic load_reg(input aes_cop_pkg::reg_idx_t idx, input aes_cop_pkg::word_t data);
        @(posedge g_clk);
        load_valid <= 1'b1;
        load_addr  <= idx;
        load_data  <= data;
        model_regs[idx] = data;
    endtask

    task automatic strobe(input aes_cop_pkg::aes_instr_t i);
        @(posedge g_clk);
        load_valid  <= 1'b0;
        instr_valid <= 1'b1;
        instr       <= i;
        @(posedge g_clk);
        instr_valid <= 1'b0;
        n_instr++;
    endtask

    task automatic wait_done(input aes_cop_pkg::reg_idx_t rd);
        int n;
        n = 0;
        while (!done && n < 10) begin
            @(posedge g_clk);
            n++;
        end
        if (!done) begin
            wait_errors++;
            $display("No done pulse for the instruction writing x%0d", rd);
        end
    endtask

    task automatic run_instr(input aes_cop_pkg::sclass_t sc, input aes_cop_pkg::reg_idx_t rd,
                             input aes_cop_pkg::reg_idx_t rs1, input aes_cop_pkg::reg_idx_t rs2,
                             input aes_cop_pkg::word_t ex);
        exp_word = ex;
        read_addr <= rd;
        strobe('{cls: `AES_COP_CLASS_AES, subclass: sc, rd: rd, rs1: rs1, rs2: rs2});
        wait_done(rd);
        model_regs[rd] = ex;
    endtask

    task automatic run_op(input aes_cop_pkg::sclass_t sc, input aes_cop_pkg::reg_idx_t rd,
                          input aes_cop_pkg::reg_idx_t rs1, input aes_cop_pkg::reg_idx_t rs2);
        run_instr(sc, rd, rs1, rs2, expected_result(sc, model_regs[rs1], model_regs[rs2]));
    endtask

    task automatic run_illegal(input aes_cop_pkg::class_t cls, input aes_cop_pkg::sclass_t sc,
                               input aes_cop_pkg::reg_idx_t rd);
        int n;
        exp_word = model_regs[rd];    // Register must keep its value
        read_addr <= rd;
        strobe('{cls: cls, subclass: sc, rd: rd, rs1: 4'd1, rs2: 4'd2});
        n = 0;
        while (!illegal && n < 4) begin
            @(posedge g_clk);
            n++;
        end
        if (!illegal) begin
            wait_errors++;
            $display("No illegal pulse for class %h subclass %h", cls, sc);
        end
    endtask

    initial begin
        aes_cop_pkg::word_t a;
        aes_cop_pkg::word_t b;
        aes_cop_pkg::word_t e;
        seed = 87;
        for (int x = 0; x < 256; x++) begin
            sbox_fwd[x] = affine(field_inverse(8'(x)));
            sbox_inv[sbox_fwd[x]] = 8'(x);
        end
        for (int r = 0; r < 16; r++) begin
            model_regs[r] = '0;
        end
        sub_codes[0] = `AES_COP_SC_SUB_ENC;
        sub_codes[1] = `AES_COP_SC_SUB_ENCROT;
        sub_codes[2] = `AES_COP_SC_SUB_DEC;
        sub_codes[3] = `AES_COP_SC_SUB_DECROT;
        g_resetn    = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        load_valid  = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        read_addr   = '0;
        zero_check  = 1'b0;
        exp_word    = '0;
        repeat (3) @(posedge g_clk);
        g_resetn <= 1'b1;

        // Idle flags and cleared registers
        for (int r = 0; r < 16; r++) begin
            @(posedge g_clk);
            zero_check <= 1'b1;
            read_addr  <= 4'(r);
        end
        @(posedge g_clk);
        zero_check <= 1'b0;

        // SubBytes in all four forms
        for (int r = 0; r < 3; r++) begin
            for (int v = 0; v < 4; v++) begin
                load_reg(4'd1, $random(seed));
                load_reg(4'd2, $random(seed));
                run_op(sub_codes[v], 4'(3 + v), 4'd1, 4'd2);
            end
        end

        for (int r = 0; r < 3; r++) begin
            load_reg(4'd1, $random(seed));
            load_reg(4'd2, $random(seed));
            run_op(`AES_COP_SC_MIX_ENC, 4'd7, 4'd1, 4'd2);
            run_op(`AES_COP_SC_MIX_DEC, 4'd8, 4'd1, 4'd2);
        end

        // Inverse MixColumn of the byte reversed result gives back the column
        load_reg(4'd1, $random(seed));
        load_reg(4'd2, $random(seed));
        a = model_regs[1];
        b = model_regs[2];
        run_op(`AES_COP_SC_MIX_ENC, 4'd9, 4'd1, 4'd2);
        e = model_regs[9];
        load_reg(4'd10, {e[7:0], e[15:8], e[23:16], e[31:24]});
        run_instr(`AES_COP_SC_MIX_DEC, 4'd11, 4'd10, 4'd10,
                  {a[7:0], b[15:8], a[23:16], b[31:24]});

        run_illegal(4'h3, `AES_COP_SC_SUB_ENC, 4'd3);
        run_illegal(`AES_COP_CLASS_AES, 5'h00, 4'd4);
        run_illegal(`AES_COP_CLASS_AES, 5'h1f, 4'd5);

        // Second strobe lands while the first one runs
        load_reg(4'd1, $random(seed));
        load_reg(4'd2, $random(seed));
        exp_word = expected_result(`AES_COP_SC_SUB_DEC, model_regs[1], model_regs[2]);
        read_addr <= 4'd12;
        strobe('{cls: `AES_COP_CLASS_AES, subclass: `AES_COP_SC_SUB_DEC,
                 rd: 4'd12, rs1: 4'd1, rs2: 4'd2});
        strobe('{cls: `AES_COP_CLASS_AES, subclass: `AES_COP_SC_MIX_ENC,
                 rd: 4'd13, rs1: 4'd2, rs2: 4'd1});
        wait_done(4'd12);
        model_regs[12] = exp_word;

        // Destination equal to a source, then reused
        load_reg(4'd14, $random(seed));
        load_reg(4'd1, $random(seed));
        run_op(`AES_COP_SC_SUB_ENC, 4'd14, 4'd14, 4'd1);
        run_op(`AES_COP_SC_MIX_ENC, 4'd15, 4'd1, 4'd14);

        repeat (2) @(posedge g_clk);
        $display("Errors: %0d assertion, %0d wait; instructions: %0d",
                 assert_errors, wait_errors, n_instr);
        if (assert_errors == 0 && wait_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
